//--- hdl/asg_pkg.sv
/*
 * shared definitions for one signal generator channel
 * - sizing localparams (pointer, burst counters, sample, triggers)
 * - pointer, address and sample types
 * - configuration and status structs
 * - cpu bus request/response, sequencer item and output beat
 * - enums for bus operations and sequencer states
 */

`default_nettype none

package asg_pkg;

  ////////////////////////////////////////////////////////////
  // sizing
  ////////////////////////////////////////////////////////////

  // pointer integer and fraction bits
  localparam int unsigned CWM = 6;
  localparam int unsigned CWF = 4;
  // full pointer width
  localparam int unsigned PW = CWM + CWF;
  // burst period and repetition counters
  localparam int unsigned CWL = 12;
  localparam int unsigned CWN = 6;
  // sample width, trigger inputs
  localparam int unsigned DW = 14;
  localparam int unsigned TN = 2;
  // table entries
  localparam int unsigned DEPTH = 2 ** CWM;

  ////////////////////////////////////////////////////////////
  // basic types
  ////////////////////////////////////////////////////////////

  typedef logic [PW-1:0]  ptr_t;
  typedef logic [CWM-1:0] adr_t;
  typedef logic [DW-1:0]  smp_t;

  typedef enum logic [1:0] {
    bus_nop,
    bus_rd,
    bus_wr
  } bus_op_e;

  typedef enum logic [1:0] {
    seq_idle,
    seq_data,
    seq_gap
  } seq_state_e;

  ////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////

  // channel configuration
  typedef struct packed {
    logic [TN-1:0]  trg;
    ptr_t           siz;
    ptr_t           stp;
    ptr_t           off;
    logic           ben;
    logic           inf;
    adr_t           bdl;
    logic [CWL-1:0] bln;
    logic [CWN-1:0] bnm;
  } cfg_t;

  // burst counters and run flag
  typedef struct packed {
    logic [CWL-1:0] bln;
    logic [CWN-1:0] bnm;
    logic           run;
  } sts_t;

  typedef struct packed {
    bus_op_e op;
    adr_t    adr;
    smp_t    wdata;
  } bus_req_t;

  typedef struct packed {
    logic ack;
    smp_t rdata;
  } bus_rsp_t;

  // ren low means repeat the held sample
  typedef struct packed {
    adr_t adr;
    logic ren;
    logic lst;
  } rd_item_t;

  typedef struct packed {
    smp_t data;
    logic lst;
  } beat_t;

endpackage

`default_nettype wire

//--- hdl/asg_table.sv
/*
 * waveform table memory
 * - cpu request/acknowledge port, write and read back
 * - synchronous stream read port with enable
 */

`timescale 1ns/1ps
`default_nettype none

module asg_table (
  input  logic              sto,
  input  logic              ctl_rst,
  input  asg_pkg::bus_req_t bus_req,
  output asg_pkg::bus_rsp_t bus_rsp,
  input  logic              rd_en,
  input  asg_pkg::adr_t     rd_adr,
  output asg_pkg::smp_t     rd_data
);
  import asg_pkg::*;

  smp_t mem [0:DEPTH-1];
  logic ack_q;
  smp_t rdata_q;
  smp_t rd_q;

  ////////////////////////////////////////////////////////////
  // cpu port
  ////////////////////////////////////////////////////////////

  // write lands on the request edge
  always_ff @(posedge sto) begin
    if (bus_req.op == bus_wr) begin
      mem[bus_req.adr] <= bus_req.wdata;
    end
  end

  // read data lines up with ack
  always_ff @(posedge sto) begin
    if (bus_req.op == bus_rd) begin
      rdata_q <= mem[bus_req.adr];
    end
  end

  // ack one cycle after any non-nop request
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= (bus_req.op != bus_nop);
    end
  end

  assign bus_rsp.ack   = ack_q;
  assign bus_rsp.rdata = rdata_q;

  ////////////////////////////////////////////////////////////
  // stream port
  ////////////////////////////////////////////////////////////

  // holds last sample when not enabled
  always_ff @(posedge sto) begin
    if (rd_en) begin
      rd_q <= mem[rd_adr];
    end
  end

  assign rd_data = rd_q;

endmodule

`default_nettype wire

//--- hdl/asg_sequencer.sv
/*
 * channel sequencer
 * - masked trigger qualification, ignored while running
 * - idle/data/gap state machine for periodic and burst modes
 * - burst period and repetition counters
 * - modulo fixed point read pointer
 * - trigger and stop interrupts, trigger output
 */

`timescale 1ns/1ps
`default_nettype none

module asg_sequencer (
  input  logic                   sto,
  input  logic                   ctl_rst,
  input  asg_pkg::cfg_t          cfg,
  input  logic [asg_pkg::TN-1:0] trg_in,
  output asg_pkg::rd_item_t      item,
  output logic                   item_valid,
  input  logic                   item_ready,
  output asg_pkg::sts_t          sts,
  output logic                   irq_trg,
  output logic                   irq_stp,
  output logic                   trg_out
);
  import asg_pkg::*;

  seq_state_e     state;
  ptr_t           ptr;
  logic [CWL-1:0] bln_cnt;
  logic [CWN-1:0] bnm_cnt;
  // events
  logic           trg;
  logic           start;
  logic           adv;
  logic           burst_end;
  logic           restart;
  logic           final_item;
  // counter ends
  logic           end_bdl;
  logic           end_bln;
  logic           end_bnm;
  // pointer arithmetic, two extra bits for carry and sign
  logic [PW+1:0]  ptr_inc;
  logic [PW+1:0]  ptr_sub;
  ptr_t           ptr_nxt;

  ////////////////////////////////////////////////////////////
  // events
  ////////////////////////////////////////////////////////////

  // masked trigger
  assign trg   = |(trg_in & cfg.trg);
  // new triggers only count from idle
  assign start = (state == seq_idle) & trg;
  // one item per handshake
  assign adv   = item_valid & item_ready;

  assign end_bdl = (bln_cnt == CWL'(cfg.bdl));
  assign end_bln = (bln_cnt == cfg.bln);
  // never ends when infinite
  assign end_bnm = (bnm_cnt == cfg.bnm) & ~cfg.inf;

  assign burst_end  = adv & cfg.ben & end_bln;
  assign final_item = burst_end & end_bnm;
  assign restart    = burst_end & ~end_bnm;

  ////////////////////////////////////////////////////////////
  // state machine and burst counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      state   <= seq_idle;
      bln_cnt <= '0;
      bnm_cnt <= '0;
    end else if (start) begin
      state   <= seq_data;
      bln_cnt <= '0;
      bnm_cnt <= '0;
    end else if (adv && cfg.ben) begin
      if (end_bln) begin
        if (end_bnm) begin
          // counters keep their final values
          state <= seq_idle;
        end else begin
          // next period
          state   <= seq_data;
          bln_cnt <= '0;
          bnm_cnt <= bnm_cnt + 1'b1;
        end
      end else begin
        bln_cnt <= bln_cnt + 1'b1;
        // data part done, repeat held sample until period end
        if ((state == seq_data) && end_bdl) begin
          state <= seq_gap;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read pointer
  ////////////////////////////////////////////////////////////

  // step, then wrap by table size if past it
  assign ptr_inc = {2'b00, ptr} + {2'b00, cfg.stp} + 1'b1;
  assign ptr_sub = ptr_inc - {2'b00, cfg.siz} - 1'b1;
  assign ptr_nxt = ptr_sub[PW+1] ? ptr_inc[PW-1:0] : ptr_sub[PW-1:0];

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ptr <= '0;
    end else if (start || restart) begin
      ptr <= cfg.off;
    end else if (adv && (state == seq_data)) begin
      // gap beats leave the pointer alone
      ptr <= ptr_nxt;
    end
  end

  ////////////////////////////////////////////////////////////
  // interrupts
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      irq_trg <= 1'b0;
      irq_stp <= 1'b0;
      trg_out <= 1'b0;
    end else begin
      irq_trg <= start | restart;
      irq_stp <= final_item;
      trg_out <= irq_trg;
    end
  end

  ////////////////////////////////////////////////////////////
  // item and status
  ////////////////////////////////////////////////////////////

  assign item_valid = (state != seq_idle);

  // lst only on the final beat of a finite burst
  assign item = '{
    adr: ptr[CWF +: CWM],
    ren: (state == seq_data),
    lst: cfg.ben & end_bln & end_bnm
  };

  assign sts = '{
    bln: bln_cnt,
    bnm: bnm_cnt,
    run: item_valid
  };

endmodule

`default_nettype wire

//--- hdl/asg_stream.sv
/*
 * output stream pipeline
 * - address stage holding the sequencer item
 * - data stage: table read register plus valid and last
 * - valid/ready stall control, whole chain freezes together
 */

`timescale 1ns/1ps
`default_nettype none

module asg_stream (
  input  logic              sto,
  input  logic              ctl_rst,
  input  asg_pkg::rd_item_t item,
  input  logic              item_valid,
  output logic              item_ready,
  output logic              rd_en,
  output asg_pkg::adr_t     rd_adr,
  input  asg_pkg::smp_t     rd_data,
  output asg_pkg::beat_t    beat,
  output logic              beat_valid,
  input  logic              beat_ready
);
  import asg_pkg::*;

  // both stages move together
  logic     advance;
  // address stage
  logic     a_vld;
  rd_item_t a_item;
  // data stage
  logic     d_vld;
  logic     d_lst;

  // output empty or being taken
  assign advance    = ~d_vld | beat_ready;
  assign item_ready = advance;

  ////////////////////////////////////////////////////////////
  // address stage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      a_vld <= 1'b0;
    end else if (advance) begin
      a_vld <= item_valid;
    end
  end

  always_ff @(posedge sto) begin
    if (advance) begin
      a_item <= item;
    end
  end

  // gap items skip the read, table keeps last sample
  assign rd_en  = advance & a_vld & a_item.ren;
  assign rd_adr = a_item.adr;

  ////////////////////////////////////////////////////////////
  // data stage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      d_vld <= 1'b0;
    end else if (advance) begin
      d_vld <= a_vld;
    end
  end

  always_ff @(posedge sto) begin
    if (advance) begin
      d_lst <= a_item.lst;
    end
  end

  // sample comes straight from the table read register
  assign beat.data  = rd_data;
  assign beat.lst   = d_lst;
  assign beat_valid = d_vld;

endmodule

`default_nettype wire

//--- hdl/asg.sv
/*
 * signal generator channel top level
 * - waveform table with cpu port
 * - sequencer with trigger, burst counters and pointer
 * - output stream pipeline
 */

`timescale 1ns/1ps
`default_nettype none

module asg (
  input  logic                   sto,
  input  logic                   ctl_rst,
  // cpu bus
  input  asg_pkg::bus_req_t      bus_req,
  output asg_pkg::bus_rsp_t      bus_rsp,
  // configuration and triggers
  input  asg_pkg::cfg_t          cfg,
  input  logic [asg_pkg::TN-1:0] trg_in,
  output logic                   trg_out,
  output logic                   irq_trg,
  output logic                   irq_stp,
  output asg_pkg::sts_t          sts,
  // sample stream
  output asg_pkg::beat_t         beat,
  output logic                   beat_valid,
  input  logic                   beat_ready
);
  import asg_pkg::*;

  // sequencer to stream
  rd_item_t item;
  logic     item_valid;
  logic     item_ready;
  // stream to table
  logic     rd_en;
  adr_t     rd_adr;
  smp_t     rd_data;

  asg_table table_i (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .rd_en   (rd_en),
    .rd_adr  (rd_adr),
    .rd_data (rd_data)
  );

  asg_sequencer seq_i (
    .sto        (sto),
    .ctl_rst    (ctl_rst),
    .cfg        (cfg),
    .trg_in     (trg_in),
    .item       (item),
    .item_valid (item_valid),
    .item_ready (item_ready),
    .sts        (sts),
    .irq_trg    (irq_trg),
    .irq_stp    (irq_stp),
    .trg_out    (trg_out)
  );

  asg_stream stream_i (
    .sto        (sto),
    .ctl_rst    (ctl_rst),
    .item       (item),
    .item_valid (item_valid),
    .item_ready (item_ready),
    .rd_en      (rd_en),
    .rd_adr     (rd_adr),
    .rd_data    (rd_data),
    .beat       (beat),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready)
  );

endmodule

`default_nettype wire

//--- dv/asg_assert.sv
/*
 * protocol assertions bound to the channel top level
 * - stream beat held while stalled
 * - cpu ack timing
 * - stream idle after reset, one cycle trigger pulse
 */

`timescale 1ns/1ps
`default_nettype none

module asg_assert (
  input logic              sto,
  input logic              ctl_rst,
  input asg_pkg::bus_req_t bus_req,
  input asg_pkg::bus_rsp_t bus_rsp,
  input asg_pkg::beat_t    beat,
  input logic              beat_valid,
  input logic              beat_ready,
  input logic              irq_trg
);
  import asg_pkg::*;

  ////////////////////////////////////////////////////////////
  // stream
  ////////////////////////////////////////////////////////////

  // stalled beat must not move
  assert property (@(posedge sto) disable iff (ctl_rst)
    beat_valid && !beat_ready |=> beat_valid && $stable(beat))
    else $error("beat changed while stalled");

  assert property (@(posedge sto) ctl_rst |=> !beat_valid)
    else $error("beat valid right after reset");

  ////////////////////////////////////////////////////////////
  // cpu bus and interrupts
  ////////////////////////////////////////////////////////////

  assert property (@(posedge sto) disable iff (ctl_rst)
    (bus_req.op != bus_nop) |=> bus_rsp.ack)
    else $error("no ack one cycle after request");

  assert property (@(posedge sto) disable iff (ctl_rst)
    (bus_req.op == bus_nop) |=> !bus_rsp.ack)
    else $error("ack without request");

  // pulse, never a level
  assert property (@(posedge sto) disable iff (ctl_rst) irq_trg |=> !irq_trg)
    else $error("irq_trg longer than one cycle");

endmodule

`default_nettype wire

//--- dv/asg_tb.sv
/*
 * testbench for one signal generator channel
 * - clock, reset, xorshift stimulus, random beat ready
 * - reference model of the expected beat stream
 * - compare tasks for beats, bus responses, status and flags
 * - table, periodic, burst, trigger mask and infinite burst tests
 * - watchdog and summary
 */

`timescale 1ns/1ps
`default_nettype none

module asg_tb;
  import asg_pkg::*;

  // cycle budget per test, worst case beats plus tails
  localparam int T_TABLE    = 4 * int'(DEPTH) + 2;
  localparam int T_PERIODIC = 200;
  localparam int T_BURST    = 4 * 24 + 30;
  localparam int T_MASK     = 50 + 4 * 24 + 30;
  localparam int T_INF      = 5 * 16 + 35;
  localparam int T_RESETS   = 5 * 3;
  localparam int LIMIT      =
    (T_TABLE + T_PERIODIC + T_BURST + T_MASK + T_INF + T_RESETS) * 4 + 1000;

  logic           sto;
  logic           ctl_rst;
  bus_req_t       bus_req;
  bus_rsp_t       bus_rsp;
  cfg_t           cfg;
  logic [TN-1:0]  trg_in;
  logic           trg_out;
  logic           irq_trg;
  logic           irq_stp;
  sts_t           sts;
  beat_t          beat;
  logic           beat_valid;
  logic           beat_ready;

  // model state
  smp_t           tbl [0:DEPTH-1];
  beat_t          exp_q [$];
  logic [31:0]    seed;
  // irq_trg one falling edge back, trg_out must follow it
  logic           irq_trg_q;
  // monitor control
  logic           watch;
  logic           extra_ok;
  // bookkeeping
  int             cycles;
  int             errors;
  int             err_mark;
  int             tests;
  int             failed;
  int             stp_seen;
  int             trg_seen;

  asg dut_i (
    .sto        (sto),
    .ctl_rst    (ctl_rst),
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .cfg        (cfg),
    .trg_in     (trg_in),
    .trg_out    (trg_out),
    .irq_trg    (irq_trg),
    .irq_stp    (irq_stp),
    .sts        (sts),
    .beat       (beat),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready)
  );

  bind asg asg_assert assert_i (
    .sto        (sto),
    .ctl_rst    (ctl_rst),
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .beat       (beat),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .irq_trg    (irq_trg)
  );

  initial begin
    sto = 1'b0;
    forever #2 sto = ~sto;
  end

  ////////////////////////////////////////////////////////////
  // random numbers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_beat(input beat_t got, input beat_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: beat data %h lst %b, expected data %h lst %b",
               $time, got.data, got.lst, exp.data, exp.lst);
    end
  endtask

  // rdata only compared on reads
  task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input logic chk_data);
    if (got.ack !== exp.ack || (chk_data && got.rdata !== exp.rdata)) begin
      errors++;
      $display("mismatch at %0t: ack %b rdata %h, expected ack %b rdata %h",
               $time, got.ack, got.rdata, exp.ack, exp.rdata);
    end
  endtask

  task automatic check_sts(input sts_t got, input sts_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: sts bln %0d bnm %0d run %b, expected %0d %0d %b",
               $time, got.bln, got.bnm, got.run, exp.bln, exp.bnm, exp.run);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s %b, expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // advance by stp+1, one wrap by siz+1
  function automatic ptr_t step_ptr(input ptr_t p, input cfg_t c);
    int nxt;
    nxt = int'(p) + int'(c.stp) + 1;
    if (nxt >= int'(c.siz) + 1) begin
      nxt = nxt - int'(c.siz) - 1;
    end
    return ptr_t'(nxt);
  endfunction

  task automatic model_periodic(input cfg_t c, input int n);
    ptr_t  p;
    beat_t b;
    p = c.off;
    repeat (n) begin
      b.data = tbl[p[CWF +: CWM]];
      b.lst  = 1'b0;
      exp_q.push_back(b);
      p = step_ptr(p, c);
    end
  endtask

  // data beats up to bdl, gap beats hold the last sample
  task automatic model_burst(input cfg_t c, input int periods, input logic last);
    ptr_t  p;
    smp_t  held;
    beat_t b;
    int    r;
    int    j;
    held = '0;
    for (r = 0; r < periods; r++) begin
      p = c.off;
      for (j = 0; j <= int'(c.bln); j++) begin
        if (j <= int'(c.bdl)) begin
          held = tbl[p[CWF +: CWM]];
          p = step_ptr(p, c);
        end
        b.data = held;
        b.lst  = last && (r == periods - 1) && (j == int'(c.bln));
        exp_q.push_back(b);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // one falling edge: ready draw, beat check, event counts
  task automatic tick();
    @(negedge sto);
    if (irq_stp) begin
      stp_seen++;
    end
    if (irq_trg) begin
      trg_seen++;
    end
    // trigger output is the trigger pulse one cycle late
    if (!ctl_rst) begin
      check_flag(trg_out, irq_trg_q, "trg_out");
    end
    irq_trg_q = irq_trg;
    beat_ready = (next_rand() % 100) < 70;
    if (watch && beat_valid && beat_ready) begin
      if (exp_q.size() != 0) begin
        check_beat(beat, exp_q.pop_front());
      end else if (!extra_ok) begin
        errors++;
        $display("error at %0t: beat arrived when none was expected", $time);
      end
    end
  endtask

  task automatic apply_reset();
    tick();
    watch   = 1'b0;
    ctl_rst = 1'b1;
    tick();
    tick();
    ctl_rst = 1'b0;
    exp_q.delete();
  endtask

  task automatic random_cfg(output cfg_t c);
    c     = '0;
    c.trg = '1;
    c.siz = ptr_t'(16 + next_rand() % 1008);
    c.stp = ptr_t'(next_rand() % (32'(c.siz) + 1));
    c.off = ptr_t'(next_rand() % (32'(c.siz) + 1));
  endtask

  // cfg a cycle ahead, then one trigger pulse
  task automatic start_run(input cfg_t c, input logic [TN-1:0] t);
    tick();
    cfg = c;
    tick();
    trg_in = t;
    tick();
    trg_in = '0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      tick();
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: failed with %0d errors", name, errors - err_mark);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_table();
    bus_rsp_t exp_rsp;
    adr_t     a;
    smp_t     d;
    int       i;
    err_mark = errors;
    for (i = 0; i < int'(DEPTH); i++) begin
      a = adr_t'(i);
      d = smp_t'(next_rand());
      tbl[a] = d;
      tick();
      bus_req.op    = bus_wr;
      bus_req.adr   = a;
      bus_req.wdata = d;
      tick();
      bus_req.op    = bus_nop;
      exp_rsp.ack   = 1'b1;
      exp_rsp.rdata = '0;
      check_rsp(bus_rsp, exp_rsp, 1'b0);
    end
    for (i = 0; i < int'(DEPTH); i++) begin
      a = adr_t'(i);
      tick();
      bus_req.op  = bus_rd;
      bus_req.adr = a;
      tick();
      bus_req.op    = bus_nop;
      exp_rsp.ack   = 1'b1;
      exp_rsp.rdata = tbl[a];
      check_rsp(bus_rsp, exp_rsp, 1'b1);
    end
    // ack drops after the nop
    tick();
    exp_rsp.ack = 1'b0;
    check_rsp(bus_rsp, exp_rsp, 1'b0);
    end_test("table");
  endtask

  task automatic test_periodic();
    cfg_t c;
    sts_t exp_sts;
    err_mark = errors;
    apply_reset();
    random_cfg(c);
    model_periodic(c, T_PERIODIC);
    watch    = 1'b1;
    extra_ok = 1'b1;
    start_run(c, 2'b01);
    wait_drain();
    // periodic mode leaves the counters alone
    exp_sts     = '0;
    exp_sts.run = 1'b1;
    check_sts(sts, exp_sts);
    apply_reset();
    end_test("periodic");
  endtask

  task automatic test_burst();
    cfg_t c;
    sts_t exp_sts;
    err_mark = errors;
    apply_reset();
    random_cfg(c);
    c.ben = 1'b1;
    c.bdl = adr_t'(next_rand() % 20);
    c.bln = CWL'(1 + next_rand() % 23);
    c.bnm = CWN'(next_rand() % 4);
    model_burst(c, int'(c.bnm) + 1, 1'b1);
    watch    = 1'b1;
    extra_ok = 1'b0;
    stp_seen = 0;
    start_run(c, 2'b10);
    wait_drain();
    // tail, nothing more may arrive
    repeat (30) tick();
    exp_sts.bln = c.bln;
    exp_sts.bnm = c.bnm;
    exp_sts.run = 1'b0;
    check_sts(sts, exp_sts);
    if (stp_seen != 1) begin
      errors++;
      $display("error at %0t: irq_stp seen %0d times, expected once", $time, stp_seen);
    end
    end_test("burst");
  endtask

  task automatic test_mask();
    cfg_t        c;
    sts_t        exp_sts;
    logic [31:0] r;
    err_mark = errors;
    apply_reset();
    random_cfg(c);
    c.trg = 2'b01;
    c.ben = 1'b1;
    c.bdl = adr_t'(next_rand() % 20);
    c.bln = CWL'(1 + next_rand() % 23);
    c.bnm = CWN'(next_rand() % 4);
    watch    = 1'b1;
    extra_ok = 1'b0;
    // masked input, stream must stay quiet
    start_run(c, 2'b10);
    repeat (50) tick();
    exp_sts = '0;
    check_sts(sts, exp_sts);
    model_burst(c, int'(c.bnm) + 1, 1'b1);
    trg_seen = 0;
    trg_in   = 2'b01;
    // extra triggers only while running
    while (exp_q.size() != 0) begin
      tick();
      r      = next_rand();
      trg_in = (sts.run && r[0]) ? 2'b11 : 2'b00;
    end
    trg_in = '0;
    repeat (30) tick();
    if (trg_seen != int'(c.bnm) + 1) begin
      errors++;
      $display("error at %0t: irq_trg seen %0d times, expected %0d",
               $time, trg_seen, int'(c.bnm) + 1);
    end
    end_test("trigger mask");
  endtask

  task automatic test_infinite();
    cfg_t c;
    sts_t exp_sts;
    err_mark = errors;
    apply_reset();
    random_cfg(c);
    c.ben = 1'b1;
    c.inf = 1'b1;
    c.bdl = adr_t'(next_rand() % 12);
    c.bln = CWL'(1 + next_rand() % 15);
    c.bnm = CWN'(next_rand() % 3);
    // two periods past bnm+1, never a last flag
    model_burst(c, int'(c.bnm) + 3, 1'b0);
    watch    = 1'b1;
    extra_ok = 1'b1;
    start_run(c, 2'b01);
    wait_drain();
    repeat (5) tick();
    if (!sts.run) begin
      errors++;
      $display("error at %0t: infinite burst stopped on its own", $time);
    end
    // reset in the middle of the stream
    apply_reset();
    watch    = 1'b1;
    extra_ok = 1'b0;
    repeat (30) begin
      tick();
      if (beat_valid) begin
        errors++;
        $display("error at %0t: beat valid after reset", $time);
      end
    end
    exp_sts = '0;
    check_sts(sts, exp_sts);
    end_test("infinite burst");
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    seed       = 32'h49fb;
    ctl_rst    = 1'b1;
    bus_req    = '0;
    cfg        = '0;
    trg_in     = '0;
    beat_ready = 1'b0;
    irq_trg_q  = 1'b0;
    watch      = 1'b0;
    extra_ok   = 1'b0;
    errors     = 0;
    err_mark   = 0;
    tests      = 0;
    failed     = 0;
    stp_seen   = 0;
    trg_seen   = 0;
    apply_reset();
    test_table();
    test_periodic();
    test_burst();
    test_mask();
    test_infinite();
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge sto);
      cycles++;
    end
    $display("error: run did not finish within %0d cycles", LIMIT);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
hdl/asg_pkg.sv
hdl/asg_table.sv
hdl/asg_sequencer.sv
hdl/asg_stream.sv
hdl/asg.sv
dv/asg_assert.sv
dv/asg_tb.sv

//--- run.sh
#!/bin/sh
# build and run the signal generator testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f list.f \
  --top-module asg_tb \
  -o asg_sim

./obj_dir/asg_sim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
